// File: build.f
game_pkg.sv
game_sprite.sv
game_collision.sv
game_timing.sv
game_master_fsm.sv
game_top.sv
tb_game_top.sv

// File: game_collision.sv
`timescale 1ns/1ps

module game_collision
    import game_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  xy_t  a_xy,
    input  xy_t  b_xy,

    output logic collision
);

    // one extra bit so the difference of two signed coordinates never wraps
    logic signed [COORD_W:0] dx;
    logic signed [COORD_W:0] dy;
    logic        [COORD_W:0] abs_dx;
    logic        [COORD_W:0] abs_dy;

    assign dx = a_xy.x - b_xy.x;
    assign dy = a_xy.y - b_xy.y;

    assign abs_dx = dx[COORD_W] ? -dx : dx;
    assign abs_dy = dy[COORD_W] ? -dy : dy;

    // boxes of equal size overlap when both centre distances are under one side
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            collision <= 1'b0;
        else
            collision <= (abs_dx < (COORD_W + 1)'(SPRITE_SIZE))
                      && (abs_dy < (COORD_W + 1)'(SPRITE_SIZE));
    end

endmodule

// File: game_master_fsm.sv
`timescale 1ns/1ps

module game_master_fsm
    import game_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        key,

    input  logic        target_within_screen,
    input  logic        torpedo_within_screen,
    input  logic        collision,
    input  logic        end_timer_running,

    output logic        target_write_xy,
    output logic        torpedo_write_xy,
    output logic        target_write_dxy,
    output logic        torpedo_write_dxy,
    output logic        target_enable_update,
    output logic        torpedo_enable_update,
    output logic        end_timer_start,
    output logic        game_won,

    output game_phase_e phase
);

    game_phase_e next_phase;

    logic next_target_write_xy;
    logic next_torpedo_write_xy;
    logic next_target_write_dxy;
    logic next_torpedo_write_dxy;
    logic next_target_enable_update;
    logic next_torpedo_enable_update;
    logic next_end_timer_start;
    logic next_game_won;

    logic [1:0] settle_cnt;
    logic       positions_fresh;
    logic       round_over;

    //------------------------------------------------------------
    // round end detection

    // the status inputs still describe the last round for a couple of cycles
    // after the start positions are written
    assign positions_fresh = (settle_cnt == 2'(SETTLE_CYCLES));

    assign round_over = positions_fresh
                     && (!target_within_screen || !torpedo_within_screen || collision);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            settle_cnt <= '0;
        else if (phase == PHASE_START)
            settle_cnt <= '0;
        else if (!positions_fresh)
            settle_cnt <= settle_cnt + 1'b1;
    end

    //------------------------------------------------------------
    // next phase and next outputs

    always_comb
    begin
        next_phase                 = phase;
        next_target_write_xy       = 1'b0;
        next_torpedo_write_xy      = 1'b0;
        next_target_write_dxy      = 1'b0;
        next_torpedo_write_dxy     = 1'b0;
        next_target_enable_update  = 1'b0;
        next_torpedo_enable_update = 1'b0;
        next_end_timer_start       = 1'b0;
        next_game_won              = game_won;  // held until the next start

        case (phase)
            PHASE_START:
            begin
                next_target_write_xy  = 1'b1;
                next_torpedo_write_xy = 1'b1;
                next_target_write_dxy = 1'b1;  // the torpedo velocity is written only when fired
                next_game_won         = 1'b0;
                next_phase            = PHASE_AIM;
            end

            PHASE_AIM:
            begin
                next_target_enable_update = 1'b1;

                if (key)
                    next_phase = PHASE_SHOOT;
                else if (round_over)
                begin
                    next_end_timer_start = 1'b1;
                    next_phase           = PHASE_END;
                end
            end

            PHASE_SHOOT:
            begin
                next_torpedo_write_dxy     = 1'b1;
                next_target_enable_update  = 1'b1;
                next_torpedo_enable_update = 1'b1;

                if (collision && positions_fresh)
                    next_game_won = 1'b1;

                if (round_over)
                begin
                    next_end_timer_start = 1'b1;
                    next_phase           = PHASE_END;
                end
            end

            PHASE_END:
            begin
                if (collision)  // the registered overlap can trail the move into this phase
                    next_game_won = 1'b1;

                if (!end_timer_running)
                    next_phase = PHASE_START;
            end

            default:
                next_phase = PHASE_START;
        endcase
    end

    //------------------------------------------------------------
    // registered phase and outputs

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            phase                 <= PHASE_START;
            target_write_xy       <= 1'b0;
            torpedo_write_xy      <= 1'b0;
            target_write_dxy      <= 1'b0;
            torpedo_write_dxy     <= 1'b0;
            target_enable_update  <= 1'b0;
            torpedo_enable_update <= 1'b0;
            end_timer_start       <= 1'b0;
            game_won              <= 1'b0;
        end
        else
        begin
            phase                 <= next_phase;
            target_write_xy       <= next_target_write_xy;
            torpedo_write_xy      <= next_torpedo_write_xy;
            target_write_dxy      <= next_target_write_dxy;
            torpedo_write_dxy     <= next_torpedo_write_dxy;
            target_enable_update  <= next_target_enable_update;
            torpedo_enable_update <= next_torpedo_enable_update;
            end_timer_start       <= next_end_timer_start;
            game_won              <= next_game_won;
        end
    end

    // phases follow the round order and only aim may skip ahead to end
    a_phase_legal: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(phase)
        && ((phase == $past(phase))
            || (phase == PHASE_AIM   && $past(phase) == PHASE_START)
            || (phase == PHASE_SHOOT && $past(phase) == PHASE_AIM)
            || (phase == PHASE_END   && $past(phase) != PHASE_START)
            || (phase == PHASE_START && $past(phase) == PHASE_END))
    );

    // a round starts the end timer with a single pulse
    a_timer_start_pulse: assert property (
        @(posedge clk) disable iff (reset) end_timer_start |=> !end_timer_start
    );

endmodule

// File: game_pkg.sv
package game_pkg;

    //------------------------------------------------------------
    // coordinates

    localparam int COORD_W = 8;

    // used for positions and for per-frame velocities alike
    typedef struct packed {
        logic signed [COORD_W-1:0] x;
        logic signed [COORD_W-1:0] y;
    } xy_t;

    //------------------------------------------------------------
    // playfield and sprite geometry

    localparam int SCREEN_W    = 64;
    localparam int SCREEN_H    = 48;
    localparam int SPRITE_SIZE = 8;

    localparam int SPRITE_X_MAX = SCREEN_W - SPRITE_SIZE;  // last x that keeps the sprite inside
    localparam int SPRITE_Y_MAX = SCREEN_H - SPRITE_SIZE;

    localparam xy_t TARGET_START_XY  = '{x: 0,  y: 8};
    localparam xy_t TARGET_DXY       = '{x: 1,  y: 0};
    localparam xy_t TORPEDO_START_XY = '{x: 32, y: 40};
    localparam xy_t TORPEDO_DXY      = '{x: 0,  y: -2};

    //------------------------------------------------------------
    // timing

    localparam int FRAME_CYCLES = 4;
    localparam int END_FRAMES   = 8;

    localparam int DIV_W   = $clog2(FRAME_CYCLES);
    localparam int FRAME_W = $clog2(END_FRAMES + 1);

    // a new start position needs one cycle to land in the sprite and one more
    // to pass through the registered collision check
    localparam int SETTLE_CYCLES = 2;

    //------------------------------------------------------------
    // round phases

    typedef enum logic [1:0] {
        PHASE_START = 2'd0,
        PHASE_AIM   = 2'd1,
        PHASE_SHOOT = 2'd2,
        PHASE_END   = 2'd3
    } game_phase_e;

endpackage

// File: game_sprite.sv
`timescale 1ns/1ps

module game_sprite
    import game_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic frame_tick,
    input  logic write_xy,
    input  logic write_dxy,
    input  logic enable_update,

    input  xy_t  start_xy,
    input  xy_t  start_dxy,

    output xy_t  xy,
    output logic within_screen
);

    xy_t dxy;  // velocity, added once per enabled frame

    logic step;

    assign step = enable_update && frame_tick;

    //------------------------------------------------------------
    // position and velocity

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            xy  <= '0;
            dxy <= '0;  // a sprite without a written velocity stays put
        end
        else
        begin
            if (write_xy)
                xy <= start_xy;
            else if (step)
            begin
                xy.x <= xy.x + dxy.x;
                xy.y <= xy.y + dxy.y;
            end

            if (write_dxy)
                dxy <= start_dxy;
        end
    end

    // both bounds inclusive on each axis
    assign within_screen = (xy.x >= 0) && (xy.x <= SPRITE_X_MAX)
                        && (xy.y >= 0) && (xy.y <= SPRITE_Y_MAX);

    // the controller places a sprite only while its motion is off, so a
    // write never races a frame step
    a_write_not_during_step: assert property (
        @(posedge clk) disable iff (reset) !(write_xy && step)
    );

endmodule

// File: game_timing.sv
`timescale 1ns/1ps

module game_timing
    import game_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic end_timer_start,

    output logic frame_tick,
    output logic end_timer_running
);

    logic [DIV_W-1:0]   div;
    logic               div_wrap;
    logic [FRAME_W-1:0] frames_left;

    //------------------------------------------------------------
    // frame strobe

    assign div_wrap = (div == DIV_W'(FRAME_CYCLES - 1));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            div        <= '0;
            frame_tick <= 1'b0;
        end
        else
        begin
            frame_tick <= div_wrap;  // registered, so the first tick lands FRAME_CYCLES after reset
            div        <= div_wrap ? '0 : div + 1'b1;
        end
    end

    //------------------------------------------------------------
    // end of game countdown

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            frames_left <= '0;
        else if (end_timer_start)
            frames_left <= FRAME_W'(END_FRAMES);
        else if (frame_tick && frames_left != '0)
            frames_left <= frames_left - 1'b1;
    end

    // start counts as running already, so the controller never sees a gap
    // between its own start pulse and the loaded count
    assign end_timer_running = end_timer_start || (frames_left != '0);

    a_start_when_idle: assert property (
        @(posedge clk) disable iff (reset) end_timer_start |-> (frames_left == '0)
    );

endmodule

// File: game_top.sv
`timescale 1ns/1ps

module game_top
    import game_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        key,

    output game_phase_e phase,
    output logic        game_won,
    output xy_t         target_xy,
    output xy_t         torpedo_xy
);

    logic frame_tick;
    logic end_timer_start;
    logic end_timer_running;
    logic collision;

    logic target_write_xy,      torpedo_write_xy;
    logic target_write_dxy,     torpedo_write_dxy;
    logic target_enable_update, torpedo_enable_update;
    logic target_within_screen, torpedo_within_screen;

    //------------------------------------------------------------
    // frame strobe and end timer

    game_timing timing
    (
        .clk               (clk),
        .reset             (reset),
        .end_timer_start   (end_timer_start),
        .frame_tick        (frame_tick),
        .end_timer_running (end_timer_running)
    );

    //------------------------------------------------------------
    // sprites

    game_sprite target_sprite
    (
        .clk           (clk),
        .reset         (reset),
        .frame_tick    (frame_tick),
        .write_xy      (target_write_xy),
        .write_dxy     (target_write_dxy),
        .enable_update (target_enable_update),
        .start_xy      (TARGET_START_XY),
        .start_dxy     (TARGET_DXY),
        .xy            (target_xy),
        .within_screen (target_within_screen)
    );

    game_sprite torpedo_sprite
    (
        .clk           (clk),
        .reset         (reset),
        .frame_tick    (frame_tick),
        .write_xy      (torpedo_write_xy),
        .write_dxy     (torpedo_write_dxy),
        .enable_update (torpedo_enable_update),
        .start_xy      (TORPEDO_START_XY),
        .start_dxy     (TORPEDO_DXY),
        .xy            (torpedo_xy),
        .within_screen (torpedo_within_screen)
    );

    game_collision collision_check
    (
        .clk       (clk),
        .reset     (reset),
        .a_xy      (target_xy),
        .b_xy      (torpedo_xy),
        .collision (collision)
    );

    //------------------------------------------------------------
    // round controller

    game_master_fsm master
    (
        .clk                   (clk),
        .reset                 (reset),
        .key                   (key),
        .target_within_screen  (target_within_screen),
        .torpedo_within_screen (torpedo_within_screen),
        .collision             (collision),
        .end_timer_running     (end_timer_running),
        .target_write_xy       (target_write_xy),
        .torpedo_write_xy      (torpedo_write_xy),
        .target_write_dxy      (target_write_dxy),
        .torpedo_write_dxy     (torpedo_write_dxy),
        .target_enable_update  (target_enable_update),
        .torpedo_enable_update (torpedo_enable_update),
        .end_timer_start       (end_timer_start),
        .game_won              (game_won),
        .phase                 (phase)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# builds the testbench and the design with Verilator and runs the simulation

LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_game_top \
    -f build.f -o sim_tb_game_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_game_top > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

exit 0

// File: tb_game_top.sv
`timescale 1ns/1ps

module tb_game_top
    import game_pkg::*;
();

    //------------------------------------------------------------
    // round table

    localparam int NUM_CASES = 6;

    // aim frame at which key goes down, zero means the round is played without a shot
    localparam int PRESS_FRAMES [NUM_CASES] = '{0, 20, 2, 10, 40, 30};

    localparam longint WATCHDOG_NS =
        longint'(NUM_CASES) * (SCREEN_W + END_FRAMES + 8) * FRAME_CYCLES * 100;

    typedef struct packed {
        logic won;
        xy_t  target_xy;
        xy_t  torpedo_xy;
    } round_result_t;

    typedef struct packed {
        int            press_frame;
        round_result_t expected;
    } round_case_t;

    logic        clk;
    logic        reset;
    logic        key;
    game_phase_e phase;
    logic        game_won;
    xy_t         target_xy;
    xy_t         torpedo_xy;

    int          edge_count;  // rising edges since reset was released
    round_case_t cases [NUM_CASES];

    game_top dut
    (
        .clk        (clk),
        .reset      (reset),
        .key        (key),
        .phase      (phase),
        .game_won   (game_won),
        .target_xy  (target_xy),
        .torpedo_xy (torpedo_xy)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        if (reset)
            edge_count <= 0;
        else
            edge_count <= edge_count + 1;
    end

    //------------------------------------------------------------
    // reference model

    // the divider runs freely from reset, so a frame strobe is high in the
    // cycle after every FRAME_CYCLES-th edge
    function automatic logic frame_due();
        return (edge_count >= FRAME_CYCLES) && (edge_count % FRAME_CYCLES == 0);
    endfunction

    function automatic logic in_playfield(xy_t p);
        return (int'($signed(p.x)) >= 0) && (int'($signed(p.x)) <= SCREEN_W - SPRITE_SIZE)
            && (int'($signed(p.y)) >= 0) && (int'($signed(p.y)) <= SCREEN_H - SPRITE_SIZE);
    endfunction

    function automatic logic boxes_overlap(xy_t a, xy_t b);
        int dx;
        int dy;
        dx = int'($signed(a.x)) - int'($signed(b.x));
        dy = int'($signed(a.y)) - int'($signed(b.y));
        if (dx < 0)
            dx = -dx;
        if (dy < 0)
            dy = -dy;
        return (dx < SPRITE_SIZE) && (dy < SPRITE_SIZE);
    endfunction

    function automatic xy_t moved(xy_t p, xy_t d);
        xy_t r;
        r.x = p.x + d.x;
        r.y = p.y + d.y;
        return r;
    endfunction

    // one step per aim or shoot frame, the round stops at the first frame that ends it
    function automatic round_result_t predict_round(int press_frame);
        round_result_t r;
        int            frame;
        logic          done;

        r.won        = 1'b0;
        r.target_xy  = TARGET_START_XY;
        r.torpedo_xy = TORPEDO_START_XY;

        frame = 0;
        while (in_playfield(r.target_xy) && (press_frame == 0 || frame < press_frame))
        begin
            r.target_xy = moved(r.target_xy, TARGET_DXY);
            frame++;
        end

        done = !in_playfield(r.target_xy);  // target left before any shot
        while (!done)
        begin
            r.target_xy  = moved(r.target_xy, TARGET_DXY);
            r.torpedo_xy = moved(r.torpedo_xy, TORPEDO_DXY);
            if (boxes_overlap(r.target_xy, r.torpedo_xy))
                r.won = 1'b1;
            done = r.won || !in_playfield(r.target_xy) || !in_playfield(r.torpedo_xy);
        end
        return r;
    endfunction

    //------------------------------------------------------------
    // checks

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_xy(input string name, input xy_t actual, input xy_t expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED: %s is %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_phase(input string name, input game_phase_e actual,
                               input game_phase_e expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED: %s is %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED: %s is %h, expected %h", name, actual, expected);
            abort_run();
        end
    endtask

    //------------------------------------------------------------
    // one round from the start phase to the end of the end phase

    task automatic play_round(input round_case_t entry);
        round_result_t seen;
        int            steps;
        int            hold;

        check_phase("phase", phase, PHASE_START);
        @(negedge clk);
        check_phase("phase", phase, PHASE_AIM);
        check_flag("game_won", game_won, 1'b0);
        @(negedge clk);
        check_xy("target_xy", target_xy, TARGET_START_XY);  // placed two cycles after start
        check_xy("torpedo_xy", torpedo_xy, TORPEDO_START_XY);

        if (entry.press_frame != 0)
        begin
            steps = 0;
            while (steps < entry.press_frame)
            begin
                if (phase != PHASE_AIM)
                begin
                    $display("ERROR: the round left the aim phase before the key press");
                    abort_run();
                end
                if (frame_due())
                    steps++;
                if (steps < entry.press_frame)
                    @(negedge clk);
            end

            // this edge moves the target to the press frame
            @(posedge clk);
            key <= 1'b1;
            hold = 1 + int'($urandom % 3);
            repeat (hold) @(posedge clk);
            key <= 1'b0;
            @(negedge clk);
            check_phase("phase", phase, PHASE_SHOOT);

            @(posedge clk);
            key <= 1'b1;  // second press while the torpedo flies
            @(posedge clk);
            key <= 1'b0;
            @(negedge clk);
        end

        while (phase != PHASE_END)
            @(negedge clk);

        // a press in the end phase must leave the result alone
        @(posedge clk);
        key <= 1'b1;
        @(posedge clk);
        key <= 1'b0;
        @(negedge clk);

        while (phase == PHASE_END)
        begin
            seen.won        = game_won;
            seen.target_xy  = target_xy;
            seen.torpedo_xy = torpedo_xy;
            @(negedge clk);
        end

        check_flag("game_won", seen.won, entry.expected.won);
        check_xy("target_xy", seen.target_xy, entry.expected.target_xy);
        check_xy("torpedo_xy", seen.torpedo_xy, entry.expected.torpedo_xy);
    endtask

    //------------------------------------------------------------
    // main sequence

    initial
    begin
        void'($urandom(32'h6ddc));
        clk   = 1'b0;
        reset = 1'b1;
        key   = 1'b0;

        for (int i = 0; i < NUM_CASES; i++)
        begin
            cases[i].press_frame = PRESS_FRAMES[i];
            cases[i].expected    = predict_round(PRESS_FRAMES[i]);
        end

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        for (int i = 0; i < NUM_CASES; i++)
        begin
            $display("round %0d, key at aim frame %0d, expect won %0b",
                     i, cases[i].press_frame, cases[i].expected.won);
            play_round(cases[i]);
        end

        $display("TEST OK");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("ERROR: timeout after %0d ns, the game never reached the end phase",
                 WATCHDOG_NS);
        abort_run();
    end

endmodule
